// File: common/led_pwm_pkg.sv
package led_pwm_pkg;

    // pulse width, counted in pwm ticks
    typedef logic [15:0] pulse_width_t;

    // position in the breathing profile
    typedef logic [15:0] phase_t;

    // what a profile segment does to the width
    typedef enum logic [1:0] {
        seg_rise,
        seg_fall,
        seg_zero
    } seg_kind_e;

    //////////////////////////////
    // profile shape

    // rise, fall, dark, dark, rise, fall, rise, fall, then dark to the end
    function automatic seg_kind_e segment_kind(input phase_t seg);
        case (seg)
            16'd0, 16'd4, 16'd6: segment_kind = seg_rise;
            16'd1, 16'd5, 16'd7: segment_kind = seg_fall;
            default:             segment_kind = seg_zero;
        endcase
    endfunction

    // width at offset ofs inside a segment of the given kind
    function automatic pulse_width_t kind_width(input seg_kind_e kind, input phase_t ofs,
                                                input int seg_len, input int step);
        case (kind)
            seg_rise: kind_width = pulse_width_t'(step * (int'(ofs) + 1));
            seg_fall: kind_width = pulse_width_t'(step * (seg_len - (int'(ofs) + 1)));
            default:  kind_width = '0;
        endcase
    endfunction

    // width for an absolute phase, used to seed the profile at reset
    function automatic pulse_width_t phase_width(input phase_t phase, input int seg_len,
                                                 input int step);
        phase_t seg;
        phase_t ofs;
        seg = phase_t'(int'(phase) / seg_len);
        ofs = phase_t'(int'(phase) % seg_len);
        phase_width = kind_width(segment_kind(seg), ofs, seg_len, step);
    endfunction

endpackage

// File: verilog/pwm_timebase.sv
`timescale 1ns/1ps

module pwm_timebase #(
    parameter int TICK_BITS   = 6,
    parameter int FRAME_BITS  = 12,
    parameter int STEP_FRAMES = 2
) (
    input  logic sysclk,
    input  logic reset,
    output logic tick,
    output logic frame_start,
    output logic step
);

    // one counter covers tick prescale and ticks per frame
    localparam int CNT_BITS     = TICK_BITS + FRAME_BITS;
    // frames per step, at least one bit so the compare stays legal
    localparam int FCNT_BITS    = (STEP_FRAMES > 1) ? $clog2(STEP_FRAMES) : 1;

    logic [CNT_BITS-1:0]  count;
    logic [FCNT_BITS-1:0] frame_cnt;
    logic                 tick_wrap;
    logic                 frame_wrap;
    logic                 step_due;

    //////////////////////////////
    // wrap decode

    // low bits all ones, next clock starts a new tick
    assign tick_wrap  = &count[TICK_BITS-1:0];
    // whole counter all ones, next clock starts a new frame
    assign frame_wrap = &count;
    // last frame of a step group
    assign step_due   = (frame_cnt == FCNT_BITS'(STEP_FRAMES - 1));

    //////////////////////////////
    // counters

    always_ff @(posedge sysclk) begin
        if (reset) begin
            count     <= '0;
            frame_cnt <= '0;
        end else begin
            count <= count + 1'b1;
            // frames counted modulo STEP_FRAMES
            if (frame_wrap) begin
                frame_cnt <= step_due ? '0 : frame_cnt + 1'b1;
            end
        end
    end

    //////////////////////////////
    // strobes, one clock wide

    always_ff @(posedge sysclk) begin
        if (reset) begin
            tick        <= 1'b0;
            frame_start <= 1'b0;
            step        <= 1'b0;
        end else begin
            tick        <= tick_wrap;
            frame_start <= frame_wrap;
            // every STEP_FRAMES-th frame start also steps the profiles
            step        <= frame_wrap && step_due;
        end
    end

    // profiles advance only on a frame boundary
    a_step_on_frame: assert property (@(posedge sysclk) disable iff (reset)
        step |-> frame_start);

endmodule

// File: breath/breath_profile.sv
`timescale 1ns/1ps

module breath_profile import led_pwm_pkg::*; #(
    parameter phase_t START_PHASE = '0,
    parameter int     SEG_LEN     = 100,
    parameter int     STEP        = 20,
    parameter int     PHASE_COUNT = 1023
) (
    input  logic         sysclk,
    input  logic         reset,
    input  logic         step,
    output pulse_width_t pulse_width
);

    //////////////////////////////
    // constants

    // start position split into segment and offset
    localparam phase_t START_SEG  = phase_t'(int'(START_PHASE) / SEG_LEN);
    localparam phase_t START_OFS  = phase_t'(int'(START_PHASE) % SEG_LEN);
    // last phase before the wrap to 0
    localparam phase_t LAST_PHASE = phase_t'(PHASE_COUNT - 1);
    // last offset inside a segment
    localparam phase_t LAST_OFS   = phase_t'(SEG_LEN - 1);
    // width change per step
    localparam pulse_width_t STEP_W = pulse_width_t'(STEP);
    // peak of a rise segment
    localparam pulse_width_t MAX_W  = pulse_width_t'(STEP * SEG_LEN);

    //////////////////////////////
    // state

    phase_t       phase;
    phase_t       seg;
    phase_t       ofs;
    seg_kind_e    kind;
    pulse_width_t width;

    // lookahead for a segment boundary
    phase_t       next_seg;
    seg_kind_e    next_kind;
    pulse_width_t next_first;

    assign next_seg   = seg + 1'b1;
    assign next_kind  = segment_kind(next_seg);
    // offset 0 of the next segment
    assign next_first = kind_width(next_kind, '0, SEG_LEN, STEP);

    //////////////////////////////
    // segment FSM

    always_ff @(posedge sysclk) begin
        if (reset) begin
            // seeded from the start phase of this LED
            phase <= START_PHASE;
            seg   <= START_SEG;
            ofs   <= START_OFS;
            kind  <= segment_kind(START_SEG);
            width <= phase_width(START_PHASE, SEG_LEN, STEP);
        end else if (step) begin
            if (phase == LAST_PHASE) begin
                // end of profile, start over at segment 0
                phase <= '0;
                seg   <= '0;
                ofs   <= '0;
                kind  <= segment_kind('0);
                width <= kind_width(segment_kind('0), '0, SEG_LEN, STEP);
            end else if (ofs == LAST_OFS) begin
                // segment boundary
                phase <= phase + 1'b1;
                seg   <= next_seg;
                ofs   <= '0;
                kind  <= next_kind;
                width <= next_first;
            end else begin
                // inside a segment
                phase <= phase + 1'b1;
                ofs   <= ofs + 1'b1;
                case (kind)
                    seg_rise: width <= width + STEP_W;
                    seg_fall: width <= width - STEP_W;
                    default:  width <= '0;
                endcase
            end
        end
    end

    // registered width goes straight to the pwm
    assign pulse_width = width;

    //////////////////////////////
    // checks

    // never brighter than the top of a rise
    a_width_bound: assert property (@(posedge sysclk) disable iff (reset)
        width <= MAX_W);

endmodule

// File: breath/led_pwm.sv
`timescale 1ns/1ps

module led_pwm import led_pwm_pkg::*; #(
    parameter int FRAME_BITS = 12
) (
    input  logic         sysclk,
    input  logic         reset,
    input  logic         tick,
    input  logic         frame_start,
    input  pulse_width_t pulse_width,
    output logic         led_drive
);

    // index of the current tick inside the frame
    logic [FRAME_BITS-1:0] tick_cnt;
    // width held for the whole frame
    pulse_width_t          frame_width;
    // index and width that apply to this tick
    logic [FRAME_BITS-1:0] tick_idx;
    pulse_width_t          cur_width;

    //////////////////////////////
    // per-tick compare

    // first tick of a frame uses the width being sampled
    assign tick_idx  = frame_start ? '0 : tick_cnt + 1'b1;
    assign cur_width = frame_start ? pulse_width : frame_width;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            tick_cnt    <= '0;
            frame_width <= '0;
            led_drive   <= 1'b0;
        end else begin
            // new width only at a frame start, no glitched frames
            if (frame_start) begin
                frame_width <= pulse_width;
            end
            // count clears on frame start, led held until the next tick
            if (tick) begin
                tick_cnt  <= tick_idx;
                led_drive <= pulse_width_t'(tick_idx) < cur_width;
            end
        end
    end

    //////////////////////////////
    // checks

    // frames are built from whole ticks
    a_frame_on_tick: assert property (@(posedge sysclk) disable iff (reset)
        frame_start |-> tick);

endmodule

// File: verilog/status_led_bank.sv
`timescale 1ns/1ps

module status_led_bank import led_pwm_pkg::*; #(
    parameter int TICK_BITS     = 6,
    parameter int FRAME_BITS    = 12,
    parameter int STEP_FRAMES   = 2,
    parameter int SEG_LEN       = 100,
    parameter int STEP          = 20,
    parameter int PHASE_COUNT   = 1023,
    parameter int N_LEDS        = 4,
    parameter int PHASE_SPACING = 64
) (
    input  logic              sysclk,
    input  logic              reset,
    output logic [N_LEDS-1:0] led_drive
);

    // shared strobes
    logic tick;
    logic frame_start;
    logic step;

    // width from each profile to its pwm
    pulse_width_t pulse_width [N_LEDS];

    //////////////////////////////
    // timebase, shared by all LEDs

    pwm_timebase #(
        .TICK_BITS  (TICK_BITS),
        .FRAME_BITS (FRAME_BITS),
        .STEP_FRAMES(STEP_FRAMES)
    ) u_timebase (
        .sysclk     (sysclk),
        .reset      (reset),
        .tick       (tick),
        .frame_start(frame_start),
        .step       (step)
    );

    //////////////////////////////
    // one profile and pwm per LED

    for (genvar i = 0; i < N_LEDS; i++) begin : g_led
        // LEDs spread across the profile
        localparam phase_t LED_START = phase_t'((i * PHASE_SPACING) % PHASE_COUNT);

        breath_profile #(
            .START_PHASE(LED_START),
            .SEG_LEN    (SEG_LEN),
            .STEP       (STEP),
            .PHASE_COUNT(PHASE_COUNT)
        ) u_profile (
            .sysclk     (sysclk),
            .reset      (reset),
            .step       (step),
            .pulse_width(pulse_width[i])
        );

        led_pwm #(
            .FRAME_BITS(FRAME_BITS)
        ) u_pwm (
            .sysclk     (sysclk),
            .reset      (reset),
            .tick       (tick),
            .frame_start(frame_start),
            .pulse_width(pulse_width[i]),
            .led_drive  (led_drive[i])
        );
    end

endmodule

// File: verification/status_led_bank_tb.sv
`timescale 1ns/1ps

module status_led_bank_tb import led_pwm_pkg::*; ();

    //////////////////////////////
    // scaled-down DUT parameters
    localparam int TICK_BITS     = 1;
    localparam int FRAME_BITS    = 5;
    localparam int STEP_FRAMES   = 2;
    localparam int SEG_LEN       = 8;
    localparam int STEP          = 2;
    localparam int PHASE_COUNT   = 83;
    localparam int N_LEDS        = 3;
    localparam int PHASE_SPACING = 30;

    // frame geometry in clocks
    localparam int TICK_CLOCKS     = 2 ** TICK_BITS;
    localparam int FRAME_CLOCKS    = 2 ** (TICK_BITS + FRAME_BITS);
    localparam int TICKS_PER_FRAME = 2 ** FRAME_BITS;
    // led_drive of tick 0 appears one clock after the first frame_start
    localparam int FIRST_EDGE      = FRAME_CLOCKS + 1;
    localparam int MAX_FRAMES      = 512;
    localparam string DATA_FILE    = "verification/status_led_bank_testdata.txt";

    logic              sysclk;
    logic              reset;
    logic [N_LEDS-1:0] led_drive;

    // monitor state
    int edge_cnt;
    int early_high;
    bit in_frames;
    int frames_done;
    int high_cnt [MAX_FRAMES][N_LEDS];

    // data file row
    int           fd;
    bit           read_done;
    string        row_name;
    int           row_frame;
    pulse_width_t exp_high [N_LEDS];

    // bookkeeping
    bit timed_out;
    int last_frame;
    int tests_run;
    int tests_failed;
    int format_errors;

    status_led_bank #(
        .TICK_BITS    (TICK_BITS),
        .FRAME_BITS   (FRAME_BITS),
        .STEP_FRAMES  (STEP_FRAMES),
        .SEG_LEN      (SEG_LEN),
        .STEP         (STEP),
        .PHASE_COUNT  (PHASE_COUNT),
        .N_LEDS       (N_LEDS),
        .PHASE_SPACING(PHASE_SPACING)
    ) UUT (
        .sysclk   (sysclk),
        .reset    (reset),
        .led_drive(led_drive)
    );

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    // clocks since reset release, k after the k-th edge without reset
    always @(posedge sysclk) begin
        if (reset) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    //////////////////////////////
    // frame monitor

    // samples on the falling edge, one sample per tick once frames run
    always @(negedge sysclk) begin : frame_monitor
        int rel;
        int frame;
        int tick_idx;
        if (reset) begin
            early_high  = 0;
            in_frames   = 1'b0;
            frames_done = 0;
        end else if (edge_cnt < FIRST_EDGE) begin
            // dark window before frame 0
            if (led_drive != '0) begin
                early_high++;
            end
        end else begin
            in_frames = 1'b1;
            rel       = edge_cnt - FIRST_EDGE;
            if (rel % TICK_CLOCKS == 0) begin
                frame    = rel / FRAME_CLOCKS;
                tick_idx = (rel % FRAME_CLOCKS) / TICK_CLOCKS;
                if (frame < MAX_FRAMES) begin
                    for (int i = 0; i < N_LEDS; i++) begin
                        if (tick_idx == 0) begin
                            high_cnt[frame][i] = 0;
                        end
                        if (led_drive[i]) begin
                            high_cnt[frame][i]++;
                        end
                    end
                    // last tick closes the frame
                    if (tick_idx == TICKS_PER_FRAME - 1) begin
                        frames_done = frame + 1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // reset and waits

    task automatic hold_reset();
        repeat (3) @(posedge sysclk);
        #2;
        reset = 1'b0;
    endtask

    // reset in the middle of a frame
    task automatic mid_run_reset();
        repeat (FRAME_CLOCKS / 2 + 3) @(posedge sysclk);
        #2;
        reset = 1'b1;
        hold_reset();
    endtask

    task automatic wait_frame(input int frame);
        int waited;
        waited = 0;
        while (frames_done <= frame && waited < (frame + 3) * FRAME_CLOCKS) begin
            @(posedge sysclk);
            waited++;
        end
        if (frames_done <= frame) begin
            $display("ERROR: frame %0d never completed before the timeout", frame);
            timed_out = 1'b1;
        end
    endtask

    //////////////////////////////
    // checks

    // led_drive low from reset release up to frame 0
    task automatic check_dark(input string name);
        int waited;
        bit bad;
        waited = 0;
        bad    = 1'b0;
        while (!in_frames && waited < 2 * FRAME_CLOCKS) begin
            @(posedge sysclk);
            waited++;
        end
        if (!in_frames) begin
            $display("ERROR: %s timed out, frames never started after reset", name);
            timed_out = 1'b1;
        end else begin
            tests_run++;
            assert (early_high == 0) else begin
                $display("CHECK FAILED %s high samples before frame 0: expected 0 actual %0d",
                         name, early_high);
                bad = 1'b1;
            end
            if (bad) begin
                tests_failed++;
                $display("FAIL %s", name);
            end else begin
                $display("PASS %s", name);
            end
        end
    endtask

    task automatic check_row();
        bit bad;
        bad = 1'b0;
        tests_run++;
        for (int i = 0; i < N_LEDS; i++) begin
            assert (high_cnt[row_frame][i] == int'(exp_high[i])) else begin
                $display("CHECK FAILED %s frame %0d led %0d: expected %0d actual %0d",
                         row_name, row_frame, i, exp_high[i], high_cnt[row_frame][i]);
                bad = 1'b1;
            end
        end
        if (bad) begin
            tests_failed++;
            $display("FAIL %s frame %0d", row_name, row_frame);
        end else begin
            $display("PASS %s frame %0d", row_name, row_frame);
        end
    endtask

    // next data row, comment lines start with #
    task automatic read_row(output bit got);
        string word;
        string rest;
        int    code;
        int    value;
        got = 1'b0;
        while (!got && !read_done) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                read_done = 1'b1;
            end else if (word.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                row_name = word;
                code     = $fscanf(fd, "%d", row_frame);
                for (int i = 0; i < N_LEDS; i++) begin
                    code += $fscanf(fd, "%d", value);
                    exp_high[i] = pulse_width_t'(value);
                end
                if (code != N_LEDS + 1 || row_frame < 0 || row_frame >= MAX_FRAMES) begin
                    $display("ERROR: data row for %s is malformed", word);
                    format_errors++;
                    read_done = 1'b1;
                end else begin
                    got = 1'b1;
                end
            end
        end
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        bit got;
        reset         = 1'b1;
        read_done     = 1'b0;
        timed_out     = 1'b0;
        last_frame    = 0;
        tests_run     = 0;
        tests_failed  = 0;
        format_errors = 0;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open %s", DATA_FILE);
            format_errors++;
            read_done = 1'b1;
        end
        hold_reset();
        check_dark("dark_until_frame0");
        while (!read_done && !timed_out) begin
            read_row(got);
            if (got) begin
                // frame index going back means a fresh reset
                if (row_frame < last_frame) begin
                    mid_run_reset();
                    check_dark("dark_after_mid_reset");
                end
                if (!timed_out) begin
                    wait_frame(row_frame);
                end
                if (!timed_out) begin
                    check_row();
                end
                last_frame = row_frame;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests: %0d run, %0d passed, %0d failed", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0 && format_errors == 0 && !timed_out && tests_run > 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verification/status_led_bank_testdata.txt
# columns: test name, frame index counted from reset, expected high ticks of led 0, 1, 2
# a frame index below the one of the previous row means the DUT is reset before that row
reset_width      0   2   0   6
reset_width      1   2   0   6
rise             2   4   0   4
rise             3   4   0   4
rise             4   6   2   2
rise             7   8   4   0
rise            14  16  12   0
fall            16  14  14   0
fall            18  12  16   0
fall            20  10  14   0
fall            30   0   4   0
zero            32   0   2   0
zero            50   0  16   6
zero            63   0   4  14
rise_second     64   2   2  12
fall_second     90   4   0   0
rise_third     100   6   0   0
fall_third     120   6  16  12
zero_tail      130   0   6  10
zero_tail      150   0   0  10
wrap           164   0   0   8
wrap           165   0   0   8
wrap           166   2   0   6
wrap           167   2   0   6
wrap           168   4   0   4
wrap           180  16  12   0
wrap           196   0   4   0
wrap           230   2   2  12
after_reset      0   2   0   6
after_reset      1   2   0   6
after_reset      2   4   0   4
after_reset      4   6   2   2

// File: status_led_bank.f
common/led_pwm_pkg.sv
verilog/pwm_timebase.sv
breath/breath_profile.sv
breath/led_pwm.sv
verilog/status_led_bank.sv
verification/status_led_bank_tb.sv

// File: Bender.yml
package:
  name: status_led_bank

sources:
  # package first, then leaf modules, then the top level
  - files:
      - common/led_pwm_pkg.sv
      - verilog/pwm_timebase.sv
      - breath/breath_profile.sv
      - breath/led_pwm.sv
      - verilog/status_led_bank.sv

  # testbench
  - target: test
    files:
      - verification/status_led_bank_tb.sv
